/* break_count_table.sv */
// per-variable break-count table with a load port, plus the registered read stage for one clause
`timescale 1ns/1ns
`default_nettype none

module break_count_table (
    input  logic                                          clk_i,
    input  logic                                          rst_i,
    input  logic                                          we_i,
    input  walksat_pkg::var_id_t                          waddr_i,
    input  walksat_pkg::break_t                           wdata_i,
    input  logic                                          clause_valid_i,
    input  walksat_pkg::var_id_t [walksat_pkg::NSAT-1:0]  clause_vars_i,
    input  logic [walksat_pkg::NSAT-1:0]                  clause_lit_valid_i,
    input  walksat_pkg::rand_t                            rand_i,
    break_if.table_mp                                     bus
);
    import walksat_pkg::*;

    // one break count per variable
    break_t table_q [NUM_VARS];

    // clause pipeline register, one cycle behind the inputs
    logic               valid_q;
    var_id_t [NSAT-1:0] vars_q;
    logic [NSAT-1:0]    lit_valid_q;
    break_t [NSAT-1:0]  breaks_q;
    rand_t              rand_q;

    // load port
    // table comes out of reset all zero
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int v = 0; v < NUM_VARS; v++) begin
                table_q[v] <= '0;
            end
        end else if (we_i) begin
            table_q[waddr_i] <= wdata_i;
        end
    end

    // strobe register, cleared on reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= clause_valid_i;
        end
    end

    // clause payload, captured only on a strobe
    // reads see the table as of the previous edge, so a write lands one cycle later
    always_ff @(posedge clk_i) begin
        if (clause_valid_i) begin
            vars_q      <= clause_vars_i;
            lit_valid_q <= clause_lit_valid_i;
            rand_q      <= rand_i;
            for (int k = 0; k < NSAT; k++) begin
                breaks_q[k] <= table_q[clause_vars_i[k]];
            end
        end
    end

    // drive the clause onto the interface
    assign bus.valid     = valid_q;
    assign bus.var_ids   = vars_q;
    assign bus.lit_valid = lit_valid_q;
    assign bus.breaks    = breaks_q;
    assign bus.rand_word = rand_q;

endmodule

`default_nettype wire

/* break_if.sv */
// interface carrying one clause and its fetched break counts from the table stage onward
`timescale 1ns/1ns
`default_nettype none

interface break_if;
    import walksat_pkg::*;

    // one-cycle strobe, clause present this cycle
    logic                   valid;
    // variable index of each literal slot
    var_id_t [NSAT-1:0]     var_ids;
    // which slots hold a real literal
    logic [NSAT-1:0]        lit_valid;
    // break count fetched for each slot
    break_t [NSAT-1:0]      breaks;
    // random draw that travels with the clause
    rand_t                  rand_word;

    // table stage registers the whole clause, random word included
    modport table_mp (
        output valid,
        output var_ids,
        output lit_valid,
        output breaks,
        output rand_word
    );

    // selector only looks at counts, valids and the draw
    modport sel_mp (
        input lit_valid,
        input breaks,
        input rand_word
    );

    // commit maps the chosen slot back to a variable
    modport commit_mp (
        input valid,
        input var_ids
    );

endinterface

`default_nettype wire

/* compile.f */
walksat_pkg.sv
break_if.sv
lfsr_rng.sv
break_count_table.sv
heuristic_selector.sv
flip_commit.sv
walksat_flip_unit.sv
walksat_flip_unit_assert.sv
tb_walksat_flip_unit.sv

/* flip_commit.sv */
// registers the chosen literal, flips its variable in the assignment and pulses the flip report
`timescale 1ns/1ns
`default_nettype none

module flip_commit (
    input  logic                    clk_i,
    input  logic                    rst_i,
    break_if.commit_mp              bus,
    input  walksat_pkg::sel_t       select_i,
    input  logic                    random_selection_i,
    output logic                    flip_valid_o,
    output walksat_pkg::var_id_t    flip_var_o,
    output logic                    flip_random_o,
    output walksat_pkg::assign_t    assign_o
);
    import walksat_pkg::*;

    // a flip happens only for a clause that picked a slot
    logic    take;
    // variable behind the chosen slot
    var_id_t sel_var;

    logic    flip_valid_q;
    var_id_t flip_var_q;
    logic    flip_random_q;
    assign_t assign_q;

    assign take = bus.valid && (select_i != SEL_NONE);

    // slot to variable index, none code maps to 0 and is never taken
    always_comb begin
        case (select_i)
            2'd0:    sel_var = bus.var_ids[0];
            2'd1:    sel_var = bus.var_ids[1];
            2'd2:    sel_var = bus.var_ids[2];
            default: sel_var = '0;
        endcase
    end

    // control state: pulse and assignment
    // the bit toggles at the same edge that raises the pulse
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            flip_valid_q <= 1'b0;
            assign_q     <= '0;
        end else begin
            flip_valid_q <= take;
            if (take) begin
                assign_q[sel_var] <= ~assign_q[sel_var];
            end
        end
    end

    // report payload, held between flips
    always_ff @(posedge clk_i) begin
        if (take) begin
            flip_var_q    <= sel_var;
            flip_random_q <= random_selection_i;
        end
    end

    assign flip_valid_o  = flip_valid_q;
    assign flip_var_o    = flip_var_q;
    assign flip_random_o = flip_random_q;
    assign assign_o      = assign_q;

endmodule

`default_nettype wire

/* heuristic_selector.sv */
// combinational WalkSAT pick among the valid literals: zero break first, then random walk or greedy
`timescale 1ns/1ns
`default_nettype none

module heuristic_selector (
    break_if.sel_mp           bus,
    output walksat_pkg::sel_t select_o,
    output logic              random_selection_o
);
    import walksat_pkg::*;

    // valid literals with a zero break count
    logic [NSAT-1:0]     zero_valid;
    logic                has_zero;
    // draw above threshold means random walk
    logic                random_walk;
    // number of valid literals, 0..3
    logic [SEL_BITS-1:0] num_valid;
    // lowest and highest valid slot with their counts
    sel_t                lo_slot;
    sel_t                hi_slot;
    break_t              lo_break;
    break_t              hi_break;
    // candidate picks for the multi-literal case
    sel_t                zero_slot;
    sel_t                rand_slot;
    sel_t                greedy_slot;
    sel_t                multi_slot;
    logic                multi_lit;

    // zero detect per slot, masked by literal valid
    always_comb begin
        for (int i = 0; i < NSAT; i++) begin
            zero_valid[i] = bus.lit_valid[i] && (bus.breaks[i] == '0);
        end
    end

    assign has_zero    = |zero_valid;
    assign random_walk = bus.rand_word > GREEDY_P;

    // count valids and find the outer valid slots
    // with two valids these are exactly the pair, with one they coincide
    always_comb begin
        num_valid = '0;
        lo_slot   = SEL_NONE;
        hi_slot   = SEL_NONE;
        lo_break  = '0;
        hi_break  = '0;
        for (int i = 0; i < NSAT; i++) begin
            if (bus.lit_valid[i]) begin
                num_valid = num_valid + 1'b1;
                hi_slot   = sel_t'(i);
                hi_break  = bus.breaks[i];
                if (lo_slot == SEL_NONE) begin
                    lo_slot  = sel_t'(i);
                    lo_break = bus.breaks[i];
                end
            end
        end
    end

    // highest zero literal wins, later slots override earlier ones
    always_comb begin
        zero_slot = SEL_NONE;
        for (int i = 0; i < NSAT; i++) begin
            if (zero_valid[i]) begin
                zero_slot = sel_t'(i);
            end
        end
    end

    // random walk
    // pair uses bit 7 for the higher slot, triple uses bits 5:0 mod 3
    always_comb begin
        if (num_valid == 2'd2) begin
            rand_slot = bus.rand_word[7] ? hi_slot : lo_slot;
        end else begin
            rand_slot = sel_t'(bus.rand_word[5:0] % 6'd3);
        end
    end

    // greedy minimum with fixed tie rules
    // pair: lower slot only when strictly smaller
    // triple: slot 0 only when strictly least, slot 1 on ties with the rest, else slot 2
    always_comb begin
        if (num_valid == 2'd2) begin
            greedy_slot = (lo_break < hi_break) ? lo_slot : hi_slot;
        end else if ((bus.breaks[0] < bus.breaks[1]) && (bus.breaks[0] < bus.breaks[2])) begin
            greedy_slot = 2'd0;
        end else if ((bus.breaks[1] <= bus.breaks[0]) && (bus.breaks[1] <= bus.breaks[2])) begin
            greedy_slot = 2'd1;
        end else begin
            greedy_slot = 2'd2;
        end
    end

    assign multi_lit  = num_valid >= 2'd2;
    assign multi_slot = has_zero ? zero_slot : (random_walk ? rand_slot : greedy_slot);

    // final choice by literal count
    always_comb begin
        if (multi_lit) begin
            select_o = multi_slot;
        end else if (num_valid == 2'd1) begin
            select_o = lo_slot;
        end else begin
            select_o = SEL_NONE;
        end
    end

    // flag only a true random walk, never a forced or zero pick
    assign random_selection_o = multi_lit && !has_zero && random_walk;

endmodule

`default_nettype wire

/* lfsr_rng.sv */
// 32-bit Galois LFSR that advances once per clause to give each clause its own random word
`timescale 1ns/1ns
`default_nettype none

module lfsr_rng (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               step_i,
    output walksat_pkg::rand_t rand_o
);
    import walksat_pkg::*;

    // current LFSR state
    rand_t state_q;
    // state after one shift
    rand_t state_next;

    // right-shift Galois form
    // the bit that falls out selects the feedback mask
    always_comb begin
        if (state_q[0]) begin
            state_next = (state_q >> 1) ^ LFSR_TAPS;
        end else begin
            state_next = state_q >> 1;
        end
    end

    // seed on reset so the register never sits at all zero
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= LFSR_SEED;
        end else if (step_i) begin
            state_q <= state_next;
        end
    end

    // the clause latches the current state at the same edge the LFSR steps
    assign rand_o = state_q;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
    --top-module tb_walksat_flip_unit --Mdir obj_dir -o sim_walksat

out=$(./obj_dir/sim_walksat 2>&1) || true
printf '%s\n' "$out"

# pass only when the testbench printed its pass line
printf '%s\n' "$out" | grep -q "TEST PASSED"

/* tb_walksat_flip_unit.sv */
// testbench for the WalkSAT flip stage, drives LFSR clauses and checks flips against a table model
`timescale 1ns/1ns
`default_nettype none

module tb_walksat_flip_unit;
    import walksat_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int N_CLAUSES    = 60;
    // three table loads, four clause runs with drains, reset check
    localparam int STIM_CYCLES    = 3 * NUM_VARS + 4 * (N_CLAUSES + 2) + 1;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES * 3 / 2 + RESET_CYCLES;

    // outcome classes of one clause
    localparam int K_NONE   = 0;
    localparam int K_SINGLE = 1;
    localparam int K_ZERO   = 2;
    localparam int K_MULTI  = 3;

    logic               clk_i;
    logic               rst_i;
    logic               clause_valid_i;
    var_id_t [NSAT-1:0] clause_vars_i;
    logic [NSAT-1:0]    clause_lit_valid_i;
    logic               bt_we_i;
    var_id_t            bt_addr_i;
    break_t             bt_data_i;
    logic               flip_valid_o;
    var_id_t            flip_var_o;
    logic               flip_random_o;
    assign_t            assign_o;

    // model state
    break_t             model_table [NUM_VARS];
    assign_t            model_assign;
    // expected outcome per clause, two falling edges deep
    int                 pipe_kind [2];
    var_id_t            pipe_var [2];
    var_id_t [NSAT-1:0] pipe_vars [2];
    logic [NSAT-1:0]    pipe_lv [2];

    logic [31:0]        lfsr_state = 32'h26a3;
    int                 checks = 0;
    int                 errors = 0;
    int                 tests = 0;
    int                 test_checks;
    int                 test_errors;
    int                 cycle_count = 0;

    walksat_flip_unit walksat_flip_unit_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] draw_bits(input int nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // outcome of a clause from the modeled table and the selection rules
    task automatic classify(input var_id_t [NSAT-1:0] vars, input logic [NSAT-1:0] lv,
                            output int kind, output var_id_t exp_var);
        int     n_valid;
        int     slot;
        int     lo;
        int     hi;
        break_t b [NSAT];
        n_valid = 0;
        slot    = 0;
        lo      = -1;
        hi      = 0;
        for (int k = 0; k < NSAT; k++) begin
            b[k] = model_table[vars[k]];
            if (lv[k]) begin
                n_valid++;
                if (lo < 0) lo = k;
                hi = k;
            end
        end
        kind = K_NONE;
        if (n_valid == 1) begin
            kind = K_SINGLE;
            slot = lo;
        end else if (n_valid >= 2) begin
            kind = K_MULTI;
            for (int k = 0; k < NSAT; k++) begin
                if (lv[k] && b[k] == '0) begin
                    kind = K_ZERO;
                    slot = k;
                end
            end
            // greedy tie rules, used when no zero and no random walk
            if (kind == K_MULTI && n_valid == 2) begin
                slot = (b[lo] < b[hi]) ? lo : hi;
            end else if (kind == K_MULTI) begin
                if (b[0] < b[1] && b[0] < b[2]) slot = 0;
                else if (b[1] <= b[0] && b[1] <= b[2]) slot = 1;
                else slot = 2;
            end
        end
        exp_var = vars[slot];
    endtask

    // compare the outputs with the clause issued two falling edges ago
    task automatic check_flip();
        int   kind;
        logic in_set;
        kind   = pipe_kind[1];
        in_set = 1'b0;
        if (kind != K_NONE) begin
            checks++;
            assert (flip_valid_o) else begin
                $display("flip pulse missing for an issued clause at %0t", $time);
                errors++;
            end
            if (kind == K_SINGLE) begin
                check_value("flip_random_o", 32'(flip_random_o), 32'd0);
            end
            if (kind == K_SINGLE || (kind == K_MULTI && !flip_random_o)) begin
                check_value("flip_var_o", 32'(flip_var_o), 32'(pipe_var[1]));
            end
            if (kind == K_MULTI && flip_random_o) begin
                for (int k = 0; k < NSAT; k++) begin
                    if (pipe_lv[1][k] && pipe_vars[1][k] == flip_var_o) in_set = 1'b1;
                end
                checks++;
                assert (in_set) else begin
                    $display("random flip of variable %0d is not a valid literal", flip_var_o);
                    errors++;
                end
            end
            // the reported bit is the one that must have toggled
            model_assign[flip_var_o] = ~model_assign[flip_var_o];
        end
        check_value("assign_o", 32'(assign_o), 32'(model_assign));
    endtask

    // one cycle: check, shift the expectations, drive new inputs
    task automatic step(input logic cv, input var_id_t [NSAT-1:0] vars, input logic [NSAT-1:0] lv,
                        input logic we, input var_id_t wa, input break_t wd);
        int      kind;
        var_id_t exp_var;
        @(negedge clk_i);
        check_flip();
        pipe_kind[1] = pipe_kind[0];
        pipe_var[1]  = pipe_var[0];
        pipe_vars[1] = pipe_vars[0];
        pipe_lv[1]   = pipe_lv[0];
        // the clause reads the table before this cycle's write lands
        classify(vars, lv, kind, exp_var);
        pipe_kind[0]       = cv ? kind : K_NONE;
        pipe_var[0]        = exp_var;
        pipe_vars[0]       = vars;
        pipe_lv[0]         = lv;
        clause_valid_i     = cv;
        clause_vars_i      = vars;
        clause_lit_valid_i = lv;
        bt_we_i            = we;
        bt_addr_i          = wa;
        bt_data_i          = wd;
        if (we) model_table[wa] = wd;
    endtask

    task automatic drain();
        repeat (2) step(1'b0, '0, '0, 1'b0, '0, '0);
    endtask

    // mode 0 any count, mode 1 about a quarter zeros, mode 2 nonzero 1..4 for ties
    function automatic break_t break_value(input int mode);
        if (mode == 2) return break_t'(draw_bits(2) + 1);
        if (mode == 1 && draw_bits(2) == 0) return '0;
        return break_t'(draw_bits(5));
    endfunction

    task automatic load_table(input int mode);
        for (int v = 0; v < NUM_VARS; v++) begin
            step(1'b0, '0, '0, 1'b1, var_id_t'(v), break_value(mode));
        end
    endtask

    function automatic var_id_t [NSAT-1:0] rand_vars();
        return {var_id_t'(draw_bits(4)), var_id_t'(draw_bits(4)), var_id_t'(draw_bits(4))};
    endfunction

    // two or three valid slots
    function automatic logic [NSAT-1:0] pick_multi();
        case (draw_bits(2))
            0:       return 3'b011;
            1:       return 3'b101;
            2:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    task automatic start_test();
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
    endtask

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        var_id_t [NSAT-1:0] vars;
        var_id_t            wa;
        var_id_t            last_addr;
        int                 total_errors;
        rst_i              = 1'b1;
        clause_valid_i     = 1'b0;
        clause_vars_i      = '0;
        clause_lit_valid_i = '0;
        bt_we_i            = 1'b0;
        bt_addr_i          = '0;
        bt_data_i          = '0;
        model_assign       = '0;
        last_addr          = '0;
        for (int v = 0; v < NUM_VARS; v++) model_table[v] = '0;
        for (int s = 0; s < 2; s++) pipe_kind[s] = K_NONE;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;

        start_test();
        check_value("flip_valid_o", 32'(flip_valid_o), 32'd0);
        check_value("assign_o", 32'(assign_o), 32'd0);
        finish_test("reset_state");

        start_test();
        load_table(0);
        repeat (N_CLAUSES) step(1'b1, rand_vars(), 3'(3'b001 << (draw_bits(2) % 3)), 1'b0, '0, '0);
        drain();
        finish_test("single_literal");

        start_test();
        load_table(1);
        repeat (N_CLAUSES) step(1'b1, rand_vars(), pick_multi(), 1'b0, '0, '0);
        drain();
        finish_test("zero_break");

        start_test();
        load_table(2);
        repeat (N_CLAUSES) step(1'b1, rand_vars(), pick_multi(), 1'b0, '0, '0);
        drain();
        finish_test("greedy_and_walk");

        // clause every cycle with a write every cycle, often reading last cycle's entry
        start_test();
        repeat (N_CLAUSES) begin
            vars = rand_vars();
            if (draw_bits(1) != 0) vars[0] = last_addr;
            wa = var_id_t'(draw_bits(4));
            step(1'b1, vars, 3'(draw_bits(3)), 1'b1, wa, break_value(1));
            last_addr = wa;
        end
        drain();
        finish_test("back_to_back");

        total_errors = errors + walksat_flip_unit_inst.walksat_flip_unit_assert_inst.fail_count;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d", tests, checks,
                 errors, walksat_flip_unit_inst.walksat_flip_unit_assert_inst.fail_count);
        if (total_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* walksat_flip_unit.sv */
// top level of the flip stage: table read, random source, selector and commit, plain ports only
`timescale 1ns/1ns
`default_nettype none

module walksat_flip_unit (
    input  logic                                          clk_i,
    input  logic                                          rst_i,
    // clause strobe with three literal slots
    input  logic                                          clause_valid_i,
    input  walksat_pkg::var_id_t [walksat_pkg::NSAT-1:0]  clause_vars_i,
    input  logic [walksat_pkg::NSAT-1:0]                  clause_lit_valid_i,
    // break table load port
    input  logic                                          bt_we_i,
    input  walksat_pkg::var_id_t                          bt_addr_i,
    input  walksat_pkg::break_t                           bt_data_i,
    // flip report and current assignment
    output logic                                          flip_valid_o,
    output walksat_pkg::var_id_t                          flip_var_o,
    output logic                                          flip_random_o,
    output walksat_pkg::assign_t                          assign_o
);
    import walksat_pkg::*;

    // free-running draw, stepped per clause
    rand_t rand_word;
    // selector result for the clause on the bus
    sel_t  select;
    logic  random_selection;

    // fetched clause between table stage and the rest
    break_if clause_bus ();

    // one step per incoming clause
    lfsr_rng lfsr_rng_inst (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .step_i (clause_valid_i),
        .rand_o (rand_word)
    );

    // stage 1, read counts and latch the clause with its draw
    break_count_table break_count_table_inst (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .we_i               (bt_we_i),
        .waddr_i            (bt_addr_i),
        .wdata_i            (bt_data_i),
        .clause_valid_i     (clause_valid_i),
        .clause_vars_i      (clause_vars_i),
        .clause_lit_valid_i (clause_lit_valid_i),
        .rand_i             (rand_word),
        .bus                (clause_bus.table_mp)
    );

    // pick a slot in the same cycle
    heuristic_selector heuristic_selector_inst (
        .bus                (clause_bus.sel_mp),
        .select_o           (select),
        .random_selection_o (random_selection)
    );

    // stage 2, flip and report
    flip_commit flip_commit_inst (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .bus                (clause_bus.commit_mp),
        .select_i           (select),
        .random_selection_i (random_selection),
        .flip_valid_o       (flip_valid_o),
        .flip_var_o         (flip_var_o),
        .flip_random_o      (flip_random_o),
        .assign_o           (assign_o)
    );

endmodule

`default_nettype wire

/* walksat_flip_unit_assert.sv */
// bound checker for flip pulse timing and the zero-break rule, watching the DUT ports only
`timescale 1ns/1ns
`default_nettype none

module walksat_flip_unit_assert (
    input  logic                                          clk_i,
    input  logic                                          rst_i,
    input  logic                                          clause_valid_i,
    input  walksat_pkg::var_id_t [walksat_pkg::NSAT-1:0]  clause_vars_i,
    input  logic [walksat_pkg::NSAT-1:0]                  clause_lit_valid_i,
    input  logic                                          bt_we_i,
    input  walksat_pkg::var_id_t                          bt_addr_i,
    input  walksat_pkg::break_t                           bt_data_i,
    input  logic                                          flip_valid_o,
    input  walksat_pkg::var_id_t                          flip_var_o,
    input  logic                                          flip_random_o,
    input  walksat_pkg::assign_t                          assign_o
);
    import walksat_pkg::*;

    // copy of the break table, fed from the load port
    break_t          shadow_q [NUM_VARS];
    // valid literals whose count is zero
    logic [NSAT-1:0] zero_mask;
    logic            multi_lit;
    logic            has_zero;
    // variable of the highest zero slot
    var_id_t         zero_var;
    // failures seen so far, read by the testbench at the end
    int              fail_count = 0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int v = 0; v < NUM_VARS; v++) begin
                shadow_q[v] <= '0;
            end
        end else if (bt_we_i) begin
            shadow_q[bt_addr_i] <= bt_data_i;
        end
    end

    always_comb begin
        zero_var = '0;
        for (int k = 0; k < NSAT; k++) begin
            zero_mask[k] = clause_lit_valid_i[k] && (shadow_q[clause_vars_i[k]] == '0);
            if (zero_mask[k]) begin
                zero_var = clause_vars_i[k];
            end
        end
    end

    assign has_zero  = |zero_mask;
    // at least two of the three slots valid
    assign multi_lit = (clause_lit_valid_i[0] && clause_lit_valid_i[1]) ||
                       (clause_lit_valid_i[0] && clause_lit_valid_i[2]) ||
                       (clause_lit_valid_i[1] && clause_lit_valid_i[2]);

    // outputs come out of reset cleared
    a_reset_clear: assert property (@(posedge clk_i)
        $past(rst_i) |-> !flip_valid_o && (assign_o == '0))
        else begin
            $error("flip_valid_o or assign_o not cleared after reset");
            fail_count++;
        end

    // every pulse traces back to a clause with a valid literal two edges earlier
    a_pulse_source: assert property (@(posedge clk_i) disable iff (rst_i)
        flip_valid_o |-> $past(clause_valid_i && (|clause_lit_valid_i), 2))
        else begin
            $error("flip pulse without a matching clause two cycles earlier");
            fail_count++;
        end

    // a clause with a valid literal always gets its pulse
    a_pulse_present: assert property (@(posedge clk_i) disable iff (rst_i)
        $past(clause_valid_i && (|clause_lit_valid_i), 2) |-> flip_valid_o)
        else begin
            $error("clause with a valid literal produced no flip pulse");
            fail_count++;
        end

    // zero break wins over walk and greedy, highest zero slot first
    a_zero_pick: assert property (@(posedge clk_i) disable iff (rst_i)
        $past(clause_valid_i && multi_lit && has_zero, 2) |->
            flip_valid_o && !flip_random_o && (flip_var_o == $past(zero_var, 2)))
        else begin
            $error("zero-break clause did not flip its highest zero literal");
            fail_count++;
        end

endmodule

bind walksat_flip_unit walksat_flip_unit_assert walksat_flip_unit_assert_inst (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .clause_valid_i     (clause_valid_i),
    .clause_vars_i      (clause_vars_i),
    .clause_lit_valid_i (clause_lit_valid_i),
    .bt_we_i            (bt_we_i),
    .bt_addr_i          (bt_addr_i),
    .bt_data_i          (bt_data_i),
    .flip_valid_o       (flip_valid_o),
    .flip_var_o         (flip_var_o),
    .flip_random_o      (flip_random_o),
    .assign_o           (assign_o)
);

`default_nettype wire

/* walksat_pkg.sv */
// shared widths, vector types and solver constants for the WalkSAT flip stage, imported by every block
`default_nettype none

package walksat_pkg;

    // problem size
    localparam int NUM_VARS = 16;
    // index width for NUM_VARS variables
    localparam int VAR_BITS = 4;
    // literals per clause, 3-SAT
    localparam int NSAT = 3;
    // break count width, up to 31 broken clauses
    localparam int BREAK_BITS = 5;
    // slot number width, slots 0..2 plus the none code
    localparam int SEL_BITS = 2;
    // random word width
    localparam int RAND_BITS = 32;

    // variable index
    typedef logic [VAR_BITS-1:0] var_id_t;
    // break count of one variable
    typedef logic [BREAK_BITS-1:0] break_t;
    // literal slot inside a clause
    typedef logic [SEL_BITS-1:0] sel_t;
    // one LFSR draw
    typedef logic [RAND_BITS-1:0] rand_t;
    // truth assignment, one bit per variable
    typedef logic [NUM_VARS-1:0] assign_t;

    // slot code for "no literal chosen"
    localparam sel_t SEL_NONE = 2'd3;

    // random word strictly above this value takes a random walk
    localparam rand_t GREEDY_P = 32'h6E147AE0;

    // Galois feedback mask for x^32 + x^22 + x^2 + x + 1, maximal length
    localparam rand_t LFSR_TAPS = 32'h80200003;
    // any nonzero start value works
    localparam rand_t LFSR_SEED = 32'hC0DE_5A71;

endpackage

`default_nettype wire
